//--- flist.f
verilog/trigger_pkg.sv
verilog/scope_regs_pkg.sv
verilog/wb_register_bank.sv
verilog/level_comparator.sv
verilog/fill_counter.sv
verilog/trigger_fsm.sv
verilog/trigger_engine_top.sv
sim/tb_clock_gen.sv
sim/trigger_engine_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f \
        --top-module trigger_engine_tb -o trigger_engine_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/trigger_engine_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst
);

    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 8;

    // Free running clock, low for the first half period
    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

    // Reset is released a little after an edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/trigger_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_engine_tb;

    localparam int N_TESTS = 6;
    localparam int CLOCK_PERIOD = 40;

    logic clock;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [4:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic wb_ack;
    logic [95:0] sample_data;
    logic [5:0] sample_valid;
    logic trigger_out;
    logic [15:0] trigger_point;
    logic [63:0] dma_base_addr;

    // Marks a sample on the selected channel and whether it should fire
    logic sample_mark;
    logic exp_pulse;
    // Free run windows, one tolerant of the transitions and one strict
    logic free_window;
    logic free_expected;

    int error_count;
    int tests_passed;
    int tests_failed;
    logic [31:0] lfsr_state;

    // Reference model of the trigger path
    int m_state;
    int m_count;
    int m_channel;
    int m_mode;
    int m_acq;
    logic m_prev;
    logic m_have_prev;
    logic signed [15:0] m_level;

    tb_clock_gen i_clock_gen (
        .clock(clock),
        .rst(rst)
    );

    trigger_engine_top i_dut (
        .clock(clock),
        .rst(rst),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .sample_data(sample_data),
        .sample_valid(sample_valid),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .trigger_out(trigger_out),
        .trigger_point(trigger_point),
        .dma_base_addr(dma_base_addr)
    );

    // A selected sample must give exactly the expected trigger two cycles later
    pulse_after_sample: assert property (@(posedge clock) disable iff (rst)
        $past(sample_mark, 2) |-> (trigger_out == $past(exp_pulse, 2)))
    else begin
        error_count++;
        $display("Error: %0d ns: trigger_out is %b after a selected sample", $time,
                 trigger_out);
    end

    // Outside free run a trigger can only follow a selected sample
    no_stray_trigger: assert property (@(posedge clock) disable iff (rst)
        trigger_out |-> ($past(sample_mark, 2) || free_window))
    else begin
        error_count++;
        $display("Error: %0d ns: trigger_out high with no sample to explain it", $time);
    end

    free_run_high: assert property (@(posedge clock) disable iff (rst)
        free_expected |-> trigger_out)
    else begin
        error_count++;
        $display("Error: %0d ns: trigger_out dropped during free run", $time);
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_value(output logic [15:0] v);
        v = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    // One Wishbone classic access, stb is held through the ack cycle
    task automatic bus_access(input logic we, input int idx, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        bit acked;
        acked = 1'b0;
        rdata = '0;
        @(posedge clock);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = 5'(idx * 4);
        wb_dat_w = wdata;
        for (int i = 0; i < 8 && !acked; i++) begin
            @(posedge clock);
            #1;
            if (wb_ack) begin
                acked = 1'b1;
                rdata = wb_dat_r;
            end
        end
        if (acked) begin
            @(posedge clock);
            #2;
        end else begin
            error_count++;
            $display("Bus access to register %0d got no acknowledge within 8 cycles", idx);
            #1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic bus_write(input int idx, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(1'b1, idx, wdata, unused);
    endtask

    task automatic expect_read(input int idx, input logic [31:0] expected);
        logic [31:0] data;
        bus_access(1'b0, idx, 32'h0, data);
        assert (data == expected)
        else begin
            error_count++;
            $display("Error: %0d ns: register %0d read %h, expected %h", $time, idx, data,
                     expected);
        end
    endtask

    // Puts one sample on a channel for one cycle and updates the model
    task automatic drive_sample(input int ch, input logic signed [15:0] value);
        logic [15:0] fill;
        logic above;
        logic crossing;
        logic pulse;
        logic selected;
        @(posedge clock);
        #2;
        // Other channels carry noise, but only the chosen one is valid
        for (int c = 0; c < 6; c++) begin
            random_value(fill);
            sample_data[c*16 +: 16] = fill;
        end
        sample_data[ch*16 +: 16] = value;
        sample_valid = '0;
        sample_valid[ch] = 1'b1;
        selected = (ch == m_channel);
        pulse = 1'b0;
        if (selected) begin
            above = value > m_level;
            case (m_mode)
                0: crossing = !m_prev && above;
                1: crossing = m_prev && !above;
                2: crossing = m_prev != above;
                default: crossing = 1'b0;
            endcase
            pulse = m_have_prev && crossing && m_state == 1;
            m_prev = above;
            m_have_prev = 1'b1;
            if (m_count < 32) begin
                m_count++;
            end
            if (m_state == 0 && m_count == 32) begin
                m_state = 1;
            end
            // A single shot stops right after its pulse
            if (pulse && m_acq == 1) begin
                m_state = 2;
            end
        end
        sample_mark = selected;
        exp_pulse = pulse;
        @(posedge clock);
        #2;
        sample_valid = '0;
        sample_mark = 1'b0;
        exp_pulse = 1'b0;
    endtask

    task automatic noise_sample(input int ch);
        logic [15:0] v;
        random_value(v);
        drive_sample(ch, v);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("PASS: %s", name);
        end else begin
            tests_failed++;
            $display("FAIL: %s", name);
        end
    endtask

    initial begin
        int errs;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        sample_data = '0;
        sample_valid = '0;
        sample_mark = 1'b0;
        exp_pulse = 1'b0;
        free_window = 1'b0;
        free_expected = 1'b0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr_state = 32'h4cb0_28de;
        m_state = 0;
        m_count = 0;
        m_channel = 0;
        m_mode = 0;
        m_acq = 0;
        m_prev = 1'b0;
        m_have_prev = 1'b0;
        m_level = '0;
        wait (!rst);

        // Register reset values, field widths and the side outputs
        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            expect_read(i, 32'h0);
        end
        bus_write(0, 32'hFFFF_FFFE);
        bus_write(1, 32'h1234_8765);
        bus_write(2, 32'hDEAD_BEEF);
        bus_write(3, 32'h0123_4567);
        bus_write(4, 32'hFFFF_FFF5);
        bus_write(5, 32'hABCD_9876);
        bus_write(6, 32'h0000_0007);
        expect_read(0, 32'h2);
        expect_read(1, 32'h8765);
        expect_read(2, 32'hDEAD_BEEF);
        expect_read(3, 32'h0123_4567);
        expect_read(4, 32'h5);
        expect_read(5, 32'h9876);
        expect_read(6, 32'h3);
        assert (trigger_point == 16'h9876 && dma_base_addr == 64'h0123_4567_DEAD_BEEF)
        else begin
            error_count++;
            $display("Error: %0d ns: trigger_point %h or dma_base_addr %h is wrong", $time,
                     trigger_point, dma_base_addr);
        end
        // Back to a neutral setup for the trigger tests
        bus_write(0, 32'h0);
        bus_write(1, 32'h0);
        bus_write(4, 32'h0);
        bus_write(6, 32'h0);
        finish_test("register access", errs);

        // Pretrigger fill counts only the selected channel
        errs = error_count;
        for (int i = 0; i < 31; i++) begin
            noise_sample(0);
            noise_sample(3);
        end
        expect_read(7, 32'h0);
        noise_sample(0);
        expect_read(7, 32'h1);
        finish_test("pretrigger fill", errs);

        // Edge classes against a level of 1000, equal counts as below
        errs = error_count;
        m_level = 16'sd1000;
        bus_write(1, 32'd1000);
        for (int mode = 0; mode < 4; mode++) begin
            m_mode = mode;
            bus_write(0, 32'(mode));
            drive_sample(0, 16'sd0);
            drive_sample(0, 16'sd2000);
            drive_sample(0, 16'sd3000);
            drive_sample(0, 16'sd1000);
            drive_sample(0, -16'sd500);
            drive_sample(5, 16'sd4000);
            drive_sample(0, 16'sd2000);
        end
        m_mode = 0;
        bus_write(0, 32'h0);
        finish_test("edge modes", errs);

        // New channel starts without edge history
        errs = error_count;
        drive_sample(0, -16'sd100);
        m_channel = 1;
        m_have_prev = 1'b0;
        m_prev = 1'b0;
        bus_write(4, 32'd1);
        drive_sample(1, 16'sd3000);
        drive_sample(1, -16'sd100);
        drive_sample(1, 16'sd3000);
        m_channel = 0;
        m_have_prev = 1'b0;
        m_prev = 1'b0;
        bus_write(4, 32'd0);
        finish_test("channel switch", errs);

        // One shot, stop, rearm with a fresh fill, then another shot
        errs = error_count;
        m_acq = 1;
        bus_write(6, 32'd1);
        drive_sample(0, -16'sd50);
        drive_sample(0, 16'sd2000);
        // The state moves to STOP in the cycle after the pulse
        @(posedge clock);
        expect_read(7, 32'h2);
        drive_sample(0, -16'sd50);
        drive_sample(0, 16'sd2000);
        expect_read(7, 32'h2);
        bus_write(7, 32'h0);
        m_state = 0;
        m_count = 0;
        expect_read(7, 32'h0);
        for (int i = 0; i < 32; i++) begin
            noise_sample(0);
        end
        expect_read(7, 32'h1);
        drive_sample(0, -16'sd50);
        drive_sample(0, 16'sd2000);
        @(posedge clock);
        expect_read(7, 32'h2);
        m_acq = 0;
        m_state = 1;
        bus_write(6, 32'd0);
        expect_read(7, 32'h1);
        finish_test("single shot", errs);

        // Free run holds the trigger high until the mode changes back
        errs = error_count;
        free_window = 1'b1;
        bus_write(6, 32'd2);
        expect_read(7, 32'h3);
        free_expected = 1'b1;
        repeat (10) @(posedge clock);
        #2;
        free_expected = 1'b0;
        bus_write(6, 32'd0);
        expect_read(7, 32'h1);
        assert (!trigger_out)
        else begin
            error_count++;
            $display("Error: %0d ns: trigger_out still high after free run", $time);
        end
        free_window = 1'b0;
        finish_test("free run", errs);

        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
                 error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Each test gets a generous budget of cycles
    initial begin
        #(N_TESTS * 2000 * CLOCK_PERIOD);
        $display("Simulation ran out of time before all tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fill_counter.sv
`timescale 1ns/1ps
`default_nettype none

module fill_counter (
    input wire logic clock,
    input wire logic rst,
    input wire logic sel_valid,
    input wire logic fill_restart,
    output logic fill_done
);

    typedef logic [$clog2(trigger_pkg::FILL_DEPTH + 1)-1:0] count_t;

    count_t count;

    // Stays high once the depth is reached because the count saturates there
    assign fill_done = count == count_t'(trigger_pkg::FILL_DEPTH);

    always_ff @(posedge clock) begin
        if (rst || fill_restart) begin
            count <= '0;
        end else if (sel_valid && !fill_done) begin
            count <= count + 1'b1;
        end
    end

    count_in_range: assert property (@(posedge clock) disable iff (rst)
        count <= count_t'(trigger_pkg::FILL_DEPTH));

endmodule

`default_nettype wire

//--- verilog/level_comparator.sv
`timescale 1ns/1ps
`default_nettype none

module level_comparator (
    input wire logic clock,
    input wire logic rst,
    input wire logic [trigger_pkg::N_CHANNELS*trigger_pkg::SAMPLE_WIDTH-1:0] sample_data,
    input wire logic [trigger_pkg::N_CHANNELS-1:0] sample_valid,
    input wire logic [trigger_pkg::CHANNEL_BITS-1:0] channel_sel,
    input wire logic channel_written,
    input wire logic signed [trigger_pkg::SAMPLE_WIDTH-1:0] trigger_level,
    input trigger_pkg::trigger_mode_t trigger_mode,
    output logic sel_valid,
    output logic edge_hit
);

    logic signed [trigger_pkg::SAMPLE_WIDTH-1:0] sel_data;
    logic above;
    logic prev_above;
    logic have_prev;
    logic crossing;

    // Channel codes past the last channel leave the trigger without a source
    always_comb begin
        sel_valid = 1'b0;
        sel_data = '0;
        for (int ch = 0; ch < trigger_pkg::N_CHANNELS; ch++) begin
            if (channel_sel == (trigger_pkg::CHANNEL_BITS)'(ch)) begin
                sel_valid = sample_valid[ch];
                sel_data = sample_data[ch*trigger_pkg::SAMPLE_WIDTH +: trigger_pkg::SAMPLE_WIDTH];
            end
        end
    end

    // Equal to the level counts as below
    assign above = sel_data > trigger_level;

    always_comb begin
        case (trigger_mode)
            trigger_pkg::RISING: crossing = !prev_above && above;
            trigger_pkg::FALLING: crossing = prev_above && !above;
            trigger_pkg::BOTH: crossing = prev_above != above;
            default: crossing = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst || channel_written) begin
            // Forget the last sample so the next one only seeds the history
            prev_above <= 1'b0;
            have_prev <= 1'b0;
            edge_hit <= 1'b0;
        end else begin
            edge_hit <= sel_valid && have_prev && crossing;
            if (sel_valid) begin
                prev_above <= above;
                have_prev <= 1'b1;
            end
        end
    end

    // A hit always comes from a selected sample one cycle before that flipped the above flag
    hit_after_sample: assert property (@(posedge clock) disable iff (rst)
        edge_hit |-> ($past(sel_valid) && (prev_above != $past(prev_above))));

endmodule

`default_nettype wire

//--- verilog/scope_regs_pkg.sv
`default_nettype none

package scope_regs_pkg;

    localparam int REG_WIDTH = 32;
    localparam int N_REGS = 8;

    // Byte address, so the two low bits never select a register
    localparam int ADDR_WIDTH = 5;

    // Word indices of the register map
    localparam logic [2:0] REG_TRIG_MODE = 3'd0;
    localparam logic [2:0] REG_TRIG_LEVEL = 3'd1;
    localparam logic [2:0] REG_DMA_LOW = 3'd2;
    localparam logic [2:0] REG_DMA_HIGH = 3'd3;
    localparam logic [2:0] REG_CHANNEL = 3'd4;
    localparam logic [2:0] REG_TRIG_POINT = 3'd5;
    localparam logic [2:0] REG_ACQ_MODE = 3'd6;
    // Writing here rearms the trigger, reading returns the state code
    localparam logic [2:0] REG_REARM = 3'd7;

endpackage

`default_nettype wire

//--- verilog/trigger_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_engine_top (
    input wire logic clock,
    input wire logic rst,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_we,
    input wire logic [scope_regs_pkg::ADDR_WIDTH-1:0] wb_adr,
    input wire logic [scope_regs_pkg::REG_WIDTH-1:0] wb_dat_w,
    input wire logic [trigger_pkg::N_CHANNELS*trigger_pkg::SAMPLE_WIDTH-1:0] sample_data,
    input wire logic [trigger_pkg::N_CHANNELS-1:0] sample_valid,
    output logic [scope_regs_pkg::REG_WIDTH-1:0] wb_dat_r,
    output logic wb_ack,
    output logic trigger_out,
    output logic [15:0] trigger_point,
    output logic [63:0] dma_base_addr
);

    // Configuration from the register bank
    trigger_pkg::trigger_mode_t trigger_mode;
    trigger_pkg::acq_mode_t acq_mode;
    logic [trigger_pkg::SAMPLE_WIDTH-1:0] trigger_level;
    logic [trigger_pkg::CHANNEL_BITS-1:0] channel_sel;
    logic channel_written;
    logic rearm;

    // Datapath and control handshakes
    logic sel_valid;
    logic edge_hit;
    logic fill_done;
    logic fill_restart;
    trigger_pkg::fsm_state_t state;

    wb_register_bank i_bank (
        .clock(clock),
        .rst(rst),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .state(state),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .rearm(rearm),
        .trigger_mode(trigger_mode),
        .trigger_level(trigger_level),
        .channel_sel(channel_sel),
        .acq_mode(acq_mode),
        .trigger_point(trigger_point),
        .dma_base_addr(dma_base_addr),
        .channel_written(channel_written)
    );

    level_comparator i_comparator (
        .clock(clock),
        .rst(rst),
        .sample_data(sample_data),
        .sample_valid(sample_valid),
        .channel_sel(channel_sel),
        .channel_written(channel_written),
        .trigger_level(trigger_level),
        .trigger_mode(trigger_mode),
        .sel_valid(sel_valid),
        .edge_hit(edge_hit)
    );

    fill_counter i_fill (
        .clock(clock),
        .rst(rst),
        .sel_valid(sel_valid),
        .fill_restart(fill_restart),
        .fill_done(fill_done)
    );

    trigger_fsm i_fsm (
        .clock(clock),
        .rst(rst),
        .fill_done(fill_done),
        .edge_hit(edge_hit),
        .rearm(rearm),
        .acq_mode(acq_mode),
        .state(state),
        .trigger_out(trigger_out),
        .fill_restart(fill_restart)
    );

endmodule

`default_nettype wire

//--- verilog/trigger_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_fsm (
    input wire logic clock,
    input wire logic rst,
    input wire logic fill_done,
    input wire logic edge_hit,
    input wire logic rearm,
    input trigger_pkg::acq_mode_t acq_mode,
    output trigger_pkg::fsm_state_t state,
    output logic trigger_out,
    output logic fill_restart
);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= trigger_pkg::WAIT_FILL;
            trigger_out <= 1'b0;
            fill_restart <= 1'b0;
        end else begin
            fill_restart <= 1'b0;
            case (state)
                trigger_pkg::WAIT_FILL: begin
                    trigger_out <= 1'b0;
                    // The counter still reads full in the cycle its clear is issued
                    if (fill_done && !fill_restart) begin
                        state <= trigger_pkg::RUN;
                    end
                end
                trigger_pkg::RUN: begin
                    if (acq_mode == trigger_pkg::FREE) begin
                        state <= trigger_pkg::FREE_RUN;
                        trigger_out <= 1'b1;
                    end else if (trigger_out && acq_mode == trigger_pkg::SINGLE) begin
                        // One shot taken, hold off until software rearms
                        state <= trigger_pkg::STOP;
                        trigger_out <= 1'b0;
                    end else begin
                        trigger_out <= edge_hit;
                    end
                end
                trigger_pkg::STOP: begin
                    trigger_out <= 1'b0;
                    if (acq_mode == trigger_pkg::FREE) begin
                        state <= trigger_pkg::FREE_RUN;
                        trigger_out <= 1'b1;
                    end else if (rearm) begin
                        // A new shot needs a fresh pretrigger fill
                        state <= trigger_pkg::WAIT_FILL;
                        fill_restart <= 1'b1;
                    end else if (acq_mode != trigger_pkg::SINGLE) begin
                        state <= trigger_pkg::RUN;
                    end
                end
                trigger_pkg::FREE_RUN: begin
                    if (acq_mode != trigger_pkg::FREE) begin
                        state <= trigger_pkg::RUN;
                        trigger_out <= 1'b0;
                    end else begin
                        trigger_out <= 1'b1;
                    end
                end
                default: begin
                    state <= trigger_pkg::WAIT_FILL;
                    trigger_out <= 1'b0;
                end
            endcase
        end
    end

    // No trigger may reach the memory while it is filling or stopped
    quiet_when_idle: assert property (@(posedge clock) disable iff (rst)
        (state == trigger_pkg::WAIT_FILL || state == trigger_pkg::STOP) |-> !trigger_out);

endmodule

`default_nettype wire

//--- verilog/trigger_pkg.sv
`default_nettype none

package trigger_pkg;

    // Every channel carries signed integer samples of this width
    localparam int SAMPLE_WIDTH = 16;
    localparam int N_CHANNELS = 6;
    // Wide enough to hold a channel index and the two unused codes above it
    localparam int CHANNEL_BITS = 3;

    // Selected samples needed before the pretrigger part of the buffer is full
    localparam int FILL_DEPTH = 32;

    // The codes are read back through the status register
    typedef enum logic [2:0] {
        WAIT_FILL = 3'd0,
        RUN = 3'd1,
        STOP = 3'd2,
        FREE_RUN = 3'd3
    } fsm_state_t;

    typedef enum logic [1:0] {
        RISING = 2'd0,
        FALLING = 2'd1,
        BOTH = 2'd2,
        NONE = 2'd3
    } trigger_mode_t;

    // Code 3 has no name and is handled like continuous acquisition
    typedef enum logic [1:0] {
        CONTINUOUS = 2'd0,
        SINGLE = 2'd1,
        FREE = 2'd2
    } acq_mode_t;

endpackage

`default_nettype wire

//--- verilog/wb_register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module wb_register_bank (
    input wire logic clock,
    input wire logic rst,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_we,
    input wire logic [scope_regs_pkg::ADDR_WIDTH-1:0] wb_adr,
    input wire logic [scope_regs_pkg::REG_WIDTH-1:0] wb_dat_w,
    input trigger_pkg::fsm_state_t state,
    output logic [scope_regs_pkg::REG_WIDTH-1:0] wb_dat_r,
    output logic wb_ack,
    output logic rearm,
    output trigger_pkg::trigger_mode_t trigger_mode,
    output logic [trigger_pkg::SAMPLE_WIDTH-1:0] trigger_level,
    output logic [trigger_pkg::CHANNEL_BITS-1:0] channel_sel,
    output trigger_pkg::acq_mode_t acq_mode,
    output logic [15:0] trigger_point,
    output logic [63:0] dma_base_addr,
    output logic channel_written
);

    logic bus_req;
    logic [$clog2(scope_regs_pkg::N_REGS)-1:0] word_idx;
    logic [scope_regs_pkg::REG_WIDTH-1:0] dma_low;
    logic [scope_regs_pkg::REG_WIDTH-1:0] dma_high;
    logic [scope_regs_pkg::REG_WIDTH-1:0] rd_mux;
    logic rearm_hit;

    // A new request is one that has not been acknowledged yet
    assign bus_req = wb_cyc && wb_stb && !wb_ack;
    assign word_idx = wb_adr[scope_regs_pkg::ADDR_WIDTH-1:2];
    assign dma_base_addr = {dma_high, dma_low};

    always_ff @(posedge clock) begin
        if (rst) begin
            wb_ack <= 1'b0;
            rearm_hit <= 1'b0;
            rearm <= 1'b0;
            channel_written <= 1'b0;
            trigger_mode <= trigger_pkg::RISING;
            trigger_level <= '0;
            dma_low <= '0;
            dma_high <= '0;
            channel_sel <= '0;
            trigger_point <= '0;
            acq_mode <= trigger_pkg::CONTINUOUS;
        end else begin
            wb_ack <= bus_req;
            // The rearm write is marked during ack and issued one cycle later
            rearm_hit <= bus_req && wb_we && word_idx == scope_regs_pkg::REG_REARM;
            rearm <= rearm_hit;
            // Tells the comparator that its edge history belongs to another channel
            channel_written <= bus_req && wb_we && word_idx == scope_regs_pkg::REG_CHANNEL;
            if (bus_req && wb_we) begin
                // Each field keeps only the bits it needs
                case (word_idx)
                    scope_regs_pkg::REG_TRIG_MODE:
                        trigger_mode <= trigger_pkg::trigger_mode_t'(wb_dat_w[1:0]);
                    scope_regs_pkg::REG_TRIG_LEVEL:
                        trigger_level <= wb_dat_w[trigger_pkg::SAMPLE_WIDTH-1:0];
                    scope_regs_pkg::REG_DMA_LOW:
                        dma_low <= wb_dat_w;
                    scope_regs_pkg::REG_DMA_HIGH:
                        dma_high <= wb_dat_w;
                    scope_regs_pkg::REG_CHANNEL:
                        channel_sel <= wb_dat_w[trigger_pkg::CHANNEL_BITS-1:0];
                    scope_regs_pkg::REG_TRIG_POINT:
                        trigger_point <= wb_dat_w[15:0];
                    scope_regs_pkg::REG_ACQ_MODE:
                        acq_mode <= trigger_pkg::acq_mode_t'(wb_dat_w[1:0]);
                    default: begin
                    end
                endcase
            end
        end
    end

    // Readback is zero extended from the stored field widths
    always_comb begin
        case (word_idx)
            scope_regs_pkg::REG_TRIG_MODE:
                rd_mux = {{(scope_regs_pkg::REG_WIDTH-2){1'b0}}, trigger_mode};
            scope_regs_pkg::REG_TRIG_LEVEL:
                rd_mux = {{(scope_regs_pkg::REG_WIDTH-trigger_pkg::SAMPLE_WIDTH){1'b0}},
                          trigger_level};
            scope_regs_pkg::REG_DMA_LOW:
                rd_mux = dma_low;
            scope_regs_pkg::REG_DMA_HIGH:
                rd_mux = dma_high;
            scope_regs_pkg::REG_CHANNEL:
                rd_mux = {{(scope_regs_pkg::REG_WIDTH-trigger_pkg::CHANNEL_BITS){1'b0}},
                          channel_sel};
            scope_regs_pkg::REG_TRIG_POINT:
                rd_mux = {{(scope_regs_pkg::REG_WIDTH-16){1'b0}}, trigger_point};
            scope_regs_pkg::REG_ACQ_MODE:
                rd_mux = {{(scope_regs_pkg::REG_WIDTH-2){1'b0}}, acq_mode};
            default:
                rd_mux = {{(scope_regs_pkg::REG_WIDTH-3){1'b0}}, state};
        endcase
    end

    // Read data is captured with the ack so it is stable while ack is high
    always_ff @(posedge clock) begin
        if (bus_req) begin
            wb_dat_r <= rd_mux;
        end
    end

    // The master must hold the cycle open until it has seen the ack
    ack_in_cycle: assert property (@(posedge clock) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire
